// File: common/cpuPkg.sv
`default_nettype none

package cpuPkg;

	////////////////// Memory map //////////////////
	localparam logic [31:0] ResetPc = 32'h0000_3000;
	localparam int RomDepth = 1024;
	localparam int RomAddrBits = $clog2(RomDepth);
	localparam string ProgramFile = "tb/cpu_program.hex";

	////////////////// Encodings ///////////////////
	localparam logic [5:0] OpSpecial = 6'h00;
	localparam logic [5:0] OpJ = 6'h02;
	localparam logic [5:0] OpBeq = 6'h04;
	localparam logic [5:0] OpOri = 6'h0d;
	localparam logic [5:0] OpLui = 6'h0f;
	localparam logic [5:0] OpLw = 6'h23;
	localparam logic [5:0] OpSw = 6'h2b;
	localparam logic [5:0] FunctAddu = 6'h21;
	localparam logic [5:0] FunctSubu = 6'h23;

	// Stages left before an operand is consumed
	localparam logic [1:0] TuseBranch = 2'd0;
	localparam logic [1:0] TuseAlu = 2'd1;
	localparam logic [1:0] TuseStore = 2'd2;
	localparam logic [1:0] TuseNone = 2'd3; // Operand not read

	// Stages left before a result exists, counted in EX
	localparam logic [1:0] TnewLoad = 2'd2;
	localparam logic [1:0] TnewAlu = 2'd1;
	localparam logic [1:0] TnewReady = 2'd0;

	typedef enum logic [3:0] {
		KindNop,
		KindAddu,
		KindSubu,
		KindOri,
		KindLui,
		KindLw,
		KindSw,
		KindBeq,
		KindJ
	} instrKind_e;

	typedef enum logic [1:0] {
		FwdReg,   // Register file or own stage register
		FwdIdEx,
		FwdExMem,
		FwdMemWb
	} fwdSel_e;

	///////////////// Pipeline data ////////////////
	typedef struct packed {
		logic [4:0] rAddr0;
		logic [1:0] tuse0;
		logic [4:0] rAddr1;
		logic [1:0] tuse1;
		logic [4:0] wAddr;
		logic [1:0] tnew;
	} hazInfo_t;

	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
	} ifId_t;

	typedef struct packed {
		instrKind_e kind;
		hazInfo_t haz;
		logic [31:0] rsVal;
		logic [31:0] rtVal;
		logic [31:0] imm;
		logic [31:0] pc;
		logic [31:0] knownResult; // lui value or link address
	} idEx_t;

	typedef struct packed {
		instrKind_e kind;
		hazInfo_t haz;
		logic [31:0] aluResult;
		logic [31:0] storeData;
		logic [31:0] pc;
	} exMem_t;

	typedef struct packed {
		instrKind_e kind;
		logic [4:0] wAddr;
		logic [31:0] aluResult;
		logic [31:0] loadData;
		logic [31:0] pc;
	} memWb_t;

	// Value written back to the register file
	function automatic logic [31:0] wbValueOf(input memWb_t w);
		return (w.kind == KindLw) ? w.loadData : w.aluResult;
	endfunction

endpackage

`default_nettype wire

// File: hw/cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu import cpuPkg::*; (
	input wire clk,
	input wire reset,
	output logic [31:2] PrAddr,
	input wire [31:0] PrRD,
	output logic [31:0] PrWD,
	output logic PrWE,
	output logic [31:0] CurAddr
);

	ifId_t ifId;
	idEx_t idEx;
	exMem_t exMem;
	memWb_t memWb;
	hazInfo_t idHaz;
	hazInfo_t exHaz;
	hazInfo_t memHaz;
	fwdSel_e fwdRs;
	fwdSel_e fwdRt;
	fwdSel_e fwdA;
	fwdSel_e fwdB;
	fwdSel_e fwdStore;
	logic stall;
	logic redirect;
	logic [31:0] target;
	logic [31:0] exResult;
	logic [31:0] wbData;

	/////////////////// Hazard ///////////////////
	bypassController bypassController (
		.idHaz(idHaz),
		.exHaz(exHaz),
		.memHaz(memHaz),
		.wbAddr(memWb.wAddr),
		.fwdRs(fwdRs),
		.fwdRt(fwdRt),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.fwdStore(fwdStore)
	);

	stallUnit stallUnit (
		.idHaz(idHaz),
		.exHaz(exHaz),
		.memHaz(memHaz),
		.stall(stall)
	);

	//////////////////// Stages //////////////////
	fetch fetch (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.redirect(redirect),
		.target(target),
		.ifId(ifId)
	);

	decode decode (
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.ifId(ifId),
		.memWb(memWb),        // Register file write
		.fwdRs(fwdRs),
		.fwdRt(fwdRt),
		.fwdFromEx(exResult),
		.fwdFromMem(exMem.aluResult),
		.idHaz(idHaz),
		.redirect(redirect),
		.target(target),
		.idEx(idEx)
	);

	execute execute (
		.clk(clk),
		.reset(reset),
		.idEx(idEx),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.fwdFromMem(exMem.aluResult),
		.fwdFromWb(wbData),
		.exHaz(exHaz),
		.exResult(exResult),
		.exMem(exMem)
	);

	memAccess memAccess (
		.clk(clk),
		.reset(reset),
		.exMem(exMem),
		.fwdStore(fwdStore),
		.wbValue(wbData),
		.PrRD(PrRD),
		.memHaz(memHaz),
		.PrAddr(PrAddr),
		.PrWD(PrWD),
		.PrWE(PrWE),
		.CurAddr(CurAddr),
		.memWb(memWb),
		.wbData(wbData)
	);

endmodule

`default_nettype wire

// File: hw/decode.sv
`timescale 1ns/10ps
`default_nettype none

module decode import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input wire stall,
	input ifId_t ifId,
	input memWb_t memWb,
	input fwdSel_e fwdRs,
	input fwdSel_e fwdRt,
	input wire [31:0] fwdFromEx,
	input wire [31:0] fwdFromMem,
	output hazInfo_t idHaz,
	output logic redirect,
	output logic [31:0] target,
	output idEx_t idEx
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [15:0] imm16;
	instrKind_e kind;
	logic [31:0] imm32;
	logic [31:0] regFile [32];
	logic [31:0] wbValue;
	logic [31:0] rfRs;
	logic [31:0] rfRt;
	logic [31:0] rsVal;
	logic [31:0] rtVal;
	logic [31:0] pcPlus4;
	logic [31:0] knownResult;

	assign opcode = ifId.instr[31:26];
	assign rs = ifId.instr[25:21];
	assign rt = ifId.instr[20:16];
	assign rd = ifId.instr[15:11];
	assign funct = ifId.instr[5:0];
	assign imm16 = ifId.instr[15:0];

	////////////// Instruction decode //////////////
	always_comb begin
		kind = KindNop;
		case (opcode)
			OpSpecial: begin
				if (funct == FunctAddu) kind = KindAddu;
				else if (funct == FunctSubu) kind = KindSubu;
			end
			OpOri: kind = KindOri;
			OpLui: kind = KindLui;
			OpLw: kind = KindLw;
			OpSw: kind = KindSw;
			OpBeq: kind = KindBeq;
			OpJ: kind = KindJ;
			default: kind = KindNop;
		endcase
	end

	// Unused operands read r0 so they never match a producer
	always_comb begin
		idHaz = '{rAddr0: 5'd0, tuse0: TuseNone, rAddr1: 5'd0, tuse1: TuseNone,
			wAddr: 5'd0, tnew: TnewReady};
		case (kind)
			KindAddu, KindSubu: begin
				idHaz.rAddr0 = rs;
				idHaz.tuse0 = TuseAlu;
				idHaz.rAddr1 = rt;
				idHaz.tuse1 = TuseAlu;
				idHaz.wAddr = rd;
				idHaz.tnew = TnewAlu;
			end
			KindOri: begin
				idHaz.rAddr0 = rs;
				idHaz.tuse0 = TuseAlu;
				idHaz.wAddr = rt;
				idHaz.tnew = TnewAlu;
			end
			KindLui: idHaz.wAddr = rt; // Result known here
			KindLw: begin
				idHaz.rAddr0 = rs;
				idHaz.tuse0 = TuseAlu;
				idHaz.wAddr = rt;
				idHaz.tnew = TnewLoad;
			end
			KindSw: begin
				idHaz.rAddr0 = rs;
				idHaz.tuse0 = TuseAlu;
				idHaz.rAddr1 = rt;
				idHaz.tuse1 = TuseStore; // Data needed only in MEM
			end
			KindBeq: begin
				idHaz.rAddr0 = rs;
				idHaz.tuse0 = TuseBranch;
				idHaz.rAddr1 = rt;
				idHaz.tuse1 = TuseBranch;
			end
			default: ;
		endcase
	end

	assign imm32 = (kind == KindOri) ? {16'd0, imm16} : {{16{imm16[15]}}, imm16};

	//////////////// Register file /////////////////
	assign wbValue = wbValueOf(memWb);

	always_ff @(posedge clk) begin
		if (memWb.wAddr != 5'd0)
			regFile[memWb.wAddr] <= wbValue;
	end

	// Same-cycle write is passed straight through
	always_comb begin
		if (rs == 5'd0) rfRs = 32'd0;
		else if (rs == memWb.wAddr) rfRs = wbValue;
		else rfRs = regFile[rs];
		if (rt == 5'd0) rfRt = 32'd0;
		else if (rt == memWb.wAddr) rfRt = wbValue;
		else rfRt = regFile[rt];
	end

	always_comb begin
		case (fwdRs)
			FwdIdEx: rsVal = fwdFromEx;
			FwdExMem: rsVal = fwdFromMem;
			default: rsVal = rfRs;
		endcase
		case (fwdRt)
			FwdIdEx: rtVal = fwdFromEx;
			FwdExMem: rtVal = fwdFromMem;
			default: rtVal = rfRt;
		endcase
	end

	/////////////// Branch and jump ////////////////
	assign pcPlus4 = ifId.pc + 32'd4;
	assign redirect = (kind == KindJ) || (kind == KindBeq && rsVal == rtVal);
	assign target = (kind == KindJ) ? {pcPlus4[31:28], ifId.instr[25:0], 2'b00}
		: pcPlus4 + {imm32[29:0], 2'b00};

	assign knownResult = (kind == KindLui) ? {imm16, 16'd0} : ifId.pc + 32'd8;

	always_ff @(posedge clk) begin
		if (reset || stall) begin
			idEx.kind <= KindNop; // Bubble
			idEx.haz <= '0;
		end else begin
			idEx <= '{kind: kind, haz: idHaz, rsVal: rsVal, rtVal: rtVal, imm: imm32,
				pc: ifId.pc, knownResult: knownResult};
		end
	end

endmodule

`default_nettype wire

// File: hw/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input idEx_t idEx,
	input fwdSel_e fwdA,
	input fwdSel_e fwdB,
	input wire [31:0] fwdFromMem,
	input wire [31:0] fwdFromWb,
	output hazInfo_t exHaz,
	output logic [31:0] exResult,
	output exMem_t exMem
);

	logic [31:0] aluA;
	logic [31:0] aluB;
	logic [31:0] aluOut;
	hazInfo_t nextHaz;

	assign exHaz = idEx.haz;
	assign exResult = idEx.knownResult; // Only valid when Tnew is zero

	////////////// Operand forwarding //////////////
	always_comb begin
		case (fwdA)
			FwdExMem: aluA = fwdFromMem;
			FwdMemWb: aluA = fwdFromWb;
			default: aluA = idEx.rsVal;
		endcase
		case (fwdB)
			FwdExMem: aluB = fwdFromMem;
			FwdMemWb: aluB = fwdFromWb;
			default: aluB = idEx.rtVal;
		endcase
	end

	/////////////////////// ALU ////////////////////
	always_comb begin
		case (idEx.kind)
			KindAddu: aluOut = aluA + aluB;
			KindSubu: aluOut = aluA - aluB;
			KindOri: aluOut = aluA | idEx.imm;
			KindLw, KindSw: aluOut = aluA + idEx.imm; // Address
			KindLui: aluOut = idEx.knownResult;
			default: aluOut = 32'd0;
		endcase
	end

	// One stage closer to the result
	always_comb begin
		nextHaz = idEx.haz;
		if (idEx.haz.tnew != TnewReady)
			nextHaz.tnew = idEx.haz.tnew - 2'd1;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			exMem.kind <= KindNop;
			exMem.haz <= '0;
		end else begin
			exMem <= '{kind: idEx.kind, haz: nextHaz, aluResult: aluOut, storeData: aluB,
				pc: idEx.pc};
		end
	end

endmodule

`default_nettype wire

// File: hw/fetch.sv
`timescale 1ns/10ps
`default_nettype none

module fetch import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input wire stall,
	input wire redirect,
	input wire [31:0] target,
	output ifId_t ifId
);

	logic [31:0] pc;
	logic [31:0] nextPc;
	logic [31:0] pcOffset;
	logic [RomAddrBits-1:0] romIndex;
	logic [31:0] rom [RomDepth];

	initial begin
		$readmemh(ProgramFile, rom);
	end

	assign pcOffset = pc - ResetPc;
	assign romIndex = pcOffset[RomAddrBits+1:2]; // Word index into ROM

	// Target applies after the delay slot has been fetched
	assign nextPc = redirect ? target : pc + 32'd4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= ResetPc;
			ifId <= '{instr: 32'd0, pc: ResetPc};
		end else if (!stall) begin
			pc <= nextPc;
			ifId <= '{instr: rom[romIndex], pc: pc};
		end
	end

endmodule

`default_nettype wire

// File: hw/hazard/bypassController.sv
`timescale 1ns/10ps
`default_nettype none

module bypassController import cpuPkg::*; (
	input hazInfo_t idHaz,
	input hazInfo_t exHaz,
	input hazInfo_t memHaz,
	input wire [4:0] wbAddr,
	output fwdSel_e fwdRs,
	output fwdSel_e fwdRt,
	output fwdSel_e fwdA,
	output fwdSel_e fwdB,
	output fwdSel_e fwdStore
);

	// Nearest matching producer wins, and only once its value exists
	function automatic fwdSel_e selectSrc(
		input logic [4:0] addr,
		input logic [4:0] nearAddr,
		input logic [1:0] nearTnew,
		input fwdSel_e nearSel,
		input logic [4:0] farAddr,
		input logic [1:0] farTnew,
		input fwdSel_e farSel
	);
		fwdSel_e sel;
		sel = FwdReg;
		if (addr != 5'd0) begin
			if (addr == nearAddr)
				sel = (nearTnew == TnewReady) ? nearSel : FwdReg;
			else if (addr == farAddr)
				sel = (farTnew == TnewReady) ? farSel : FwdReg;
		end
		return sel;
	endfunction

	//////////////// Into decode ///////////////////
	assign fwdRs = selectSrc(idHaz.rAddr0, exHaz.wAddr, exHaz.tnew, FwdIdEx,
		memHaz.wAddr, memHaz.tnew, FwdExMem);
	assign fwdRt = selectSrc(idHaz.rAddr1, exHaz.wAddr, exHaz.tnew, FwdIdEx,
		memHaz.wAddr, memHaz.tnew, FwdExMem);

	//////////////// Into execute //////////////////
	assign fwdA = selectSrc(exHaz.rAddr0, memHaz.wAddr, memHaz.tnew, FwdExMem,
		wbAddr, TnewReady, FwdMemWb);
	assign fwdB = selectSrc(exHaz.rAddr1, memHaz.wAddr, memHaz.tnew, FwdExMem,
		wbAddr, TnewReady, FwdMemWb);

	// Write-back is the only producer left for store data in MEM
	assign fwdStore = selectSrc(memHaz.rAddr1, wbAddr, TnewReady, FwdMemWb,
		5'd0, TnewReady, FwdReg);

endmodule

`default_nettype wire

// File: hw/hazard/stallUnit.sv
`timescale 1ns/10ps
`default_nettype none

module stallUnit import cpuPkg::*; (
	input hazInfo_t idHaz,
	input hazInfo_t exHaz,
	input hazInfo_t memHaz,
	output logic stall
);

	// Producer result arrives later than the consumer needs it
	function automatic logic tooLate(
		input logic [4:0] rAddr,
		input logic [1:0] tuse,
		input hazInfo_t producer
	);
		return (rAddr != 5'd0) && (rAddr == producer.wAddr) && (producer.tnew > tuse);
	endfunction

	assign stall = tooLate(idHaz.rAddr0, idHaz.tuse0, exHaz)
		|| tooLate(idHaz.rAddr1, idHaz.tuse1, exHaz)
		|| tooLate(idHaz.rAddr0, idHaz.tuse0, memHaz)
		|| tooLate(idHaz.rAddr1, idHaz.tuse1, memHaz);

endmodule

`default_nettype wire

// File: hw/memAccess.sv
`timescale 1ns/10ps
`default_nettype none

module memAccess import cpuPkg::*; (
	input wire clk,
	input wire reset,
	input exMem_t exMem,
	input fwdSel_e fwdStore,
	input wire [31:0] wbValue,
	input wire [31:0] PrRD,
	output hazInfo_t memHaz,
	output logic [31:2] PrAddr,
	output logic [31:0] PrWD,
	output logic PrWE,
	output logic [31:0] CurAddr,
	output memWb_t memWb,
	output logic [31:0] wbData
);

	logic [31:0] storeData;

	assign memHaz = exMem.haz;

	/////////////////// Processor bus //////////////////
	assign storeData = (fwdStore == FwdMemWb) ? wbValue : exMem.storeData;
	assign PrAddr = exMem.aluResult[31:2];
	assign PrWD = storeData;
	assign PrWE = (exMem.kind == KindSw); // One cycle per store
	assign CurAddr = exMem.pc;

	// Load data sampled at the end of the bus cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			memWb.kind <= KindNop;
			memWb.wAddr <= 5'd0;
		end else begin
			memWb <= '{kind: exMem.kind, wAddr: exMem.haz.wAddr,
				aluResult: exMem.aluResult, loadData: PrRD, pc: exMem.pc};
		end
	end

	assign wbData = wbValueOf(memWb);

endmodule

`default_nettype wire

// File: project.f
common/cpuPkg.sv
hw/hazard/bypassController.sv
hw/hazard/stallUnit.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/memAccess.sv
hw/cpu.sv
tb/cpuTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
	verilator --binary --timing -j 0 -f project.f --top-module cpuTb -Mdir obj_dir &&
	./obj_dir/VcpuTb || exit 1

// File: tb/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb;

	localparam int ClkPeriod = 4;
	localparam int ResetCycles = 2;
	localparam int DrainCycles = 8;     // Bus must stay quiet after the last store
	localparam int WatchdogFactor = 40; // Clock periods per pattern line
	localparam string PatternFile = "tb/cpu_patterns.txt";

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] pc;
	} storeExp_t;

	logic clk;
	logic reset;
	logic [31:2] PrAddr;
	logic [31:0] PrRD;
	logic [31:0] PrWD;
	logic PrWE;
	logic [31:0] CurAddr;

	logic [31:0] dataMem [logic [29:0]]; // Sparse memory keyed by word address
	storeExp_t expStores [$];
	int patternCount;
	int storeTotal;
	int storesSeen;
	logic loaded;

	cpu u_dut (
		.clk(clk),
		.reset(reset),
		.PrAddr(PrAddr),
		.PrRD(PrRD),
		.PrWD(PrWD),
		.PrWE(PrWE),
		.CurAddr(CurAddr)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic abortRun();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED at time %0t: %s expected %h, got %h", $time, name, expected, actual);
			abortRun();
		end
	endtask

	// Untouched words differ for every address
	function automatic logic [31:0] fillWord(input logic [29:0] wordAddr);
		return {wordAddr, 2'b00} ^ 32'h5a5a_a5a5;
	endfunction

	function automatic logic [31:0] readWord(input logic [29:0] wordAddr);
		if (dataMem.exists(wordAddr))
			return dataMem[wordAddr];
		return fillWord(wordAddr);
	endfunction

	task automatic loadPatterns();
		int fd;
		int fields;
		int ch;
		logic done;
		logic [63:0] tag;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		storeExp_t want;
		fd = $fopen(PatternFile, "r");
		if (fd == 0) begin
			$display("Cannot open the pattern file %s", PatternFile);
			abortRun();
		end else begin
			done = 1'b0;
			while (!done) begin
				tag = '0;
				fields = $fscanf(fd, "%s", tag);
				if (fields != 1) begin
					done = 1'b1; // End of file
				end else if (tag == 64'("mem")) begin
					fields = $fscanf(fd, "%h %h", f0, f1);
					dataMem[f0[31:2]] = f1;
					patternCount++;
				end else if (tag == 64'("store")) begin
					fields = $fscanf(fd, "%h %h %h", f0, f1, f2);
					want = '{addr: f0, data: f1, pc: f2};
					expStores.push_back(want);
					patternCount++;
				end else begin
					ch = 0;
					while (ch != 10 && ch != -1) // Skip the rest of a comment line
						ch = $fgetc(fd);
				end
			end
			$fclose(fd);
		end
	endtask

	// Next expected store must match address, data and PC
	task automatic checkStore();
		storeExp_t want;
		if (expStores.size() == 0) begin
			$display("Unexpected store to address %h at time %0t after the last expected store",
				{PrAddr, 2'b00}, $time);
			abortRun();
		end else begin
			want = expStores.pop_front();
			check("PrAddr (byte address)", {PrAddr, 2'b00}, want.addr);
			check("PrWD", PrWD, want.data);
			check("CurAddr", CurAddr, want.pc);
			storesSeen++;
		end
	endtask

	////////////////////////////////////////
	// Clock, bus model, watchdog
	////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	// Bus outputs are settled by the falling edge
	initial begin
		PrRD = 32'd0;
		forever begin
			@(negedge clk);
			if (reset) begin
				check("PrWE", {31'd0, PrWE}, 32'd0);
			end else if (PrWE) begin
				checkStore();
				dataMem[PrAddr] = PrWD;
			end
			PrRD = readWord(PrAddr); // Sampled by the core at the next rising edge
		end
	end

	initial begin
		wait (loaded);
		repeat (WatchdogFactor * patternCount) @(posedge clk);
		$display("Timeout: the store sequence did not finish within %0d clock periods",
			WatchdogFactor * patternCount);
		abortRun();
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		reset = 1'b1;
		loaded = 1'b0;
		patternCount = 0;
		storesSeen = 0;
		loadPatterns();
		storeTotal = expStores.size();
		loaded = 1'b1;
		repeat (ResetCycles) @(negedge clk);
		reset = 1'b0;
		while (storesSeen < storeTotal)
			@(posedge clk);
		repeat (DrainCycles) @(negedge clk); // Wrong-path stores would show up here
		if (storesSeen == storeTotal && storeTotal > 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("The store sequence did not complete as expected");
			abortRun();
		end
	end

endmodule

`default_nettype wire

// File: tb/cpu_patterns.txt
# mem   <byte address> <preset data word>
# store <PrAddr as byte address> <PrWD> <CurAddr>
mem 00000100 cafe0000
mem 00000104 0badf00d
# ALU results, back-to-back forwarding
store 00000000 12345678 00003014
store 00000004 12340000 00003018
store 00000008 123400ff 0000301c
# Load-use stall, then store-data forwarding
store 0000000c cafe5678 00003028
store 00000010 0badf00d 00003030
# beq not taken, delay slot and fall-through
store 00000014 12340000 00003038
store 00000018 00005678 0000303c
# beq taken, only the delay slot
store 0000001c 123400ff 00003044
# j, only the delay slot
store 00000024 cafe5678 00003050

// File: tb/cpu_program.hex
// One instruction word per line, the first at 0x3000
// word      address  assembly
3c011234 // 3000 lui  r1, 0x1234
34025678 // 3004 ori  r2, r0, 0x5678
00221821 // 3008 addu r3, r1, r2
00622023 // 300c subu r4, r3, r2
342500ff // 3010 ori  r5, r1, 0x00ff
ac030000 // 3014 sw   r3, 0x00(r0)
ac040004 // 3018 sw   r4, 0x04(r0)
ac050008 // 301c sw   r5, 0x08(r0)
8c060100 // 3020 lw   r6, 0x100(r0)
00c23821 // 3024 addu r7, r6, r2
ac07000c // 3028 sw   r7, 0x0c(r0)
8c080104 // 302c lw   r8, 0x104(r0)
ac080010 // 3030 sw   r8, 0x10(r0)
11060002 // 3034 beq  r8, r6, 0x3040
ac010014 // 3038 sw   r1, 0x14(r0)
ac020018 // 303c sw   r2, 0x18(r0)
10630002 // 3040 beq  r3, r3, 0x304c
ac05001c // 3044 sw   r5, 0x1c(r0)
ac010020 // 3048 sw   r1, 0x20(r0)
08000c16 // 304c j    0x3058
ac070024 // 3050 sw   r7, 0x24(r0)
ac020028 // 3054 sw   r2, 0x28(r0)
08000c16 // 3058 j    0x3058
00000000 // 305c nop
